//--- sources.f
+incdir+hw
hw/mem_pkg.sv
hw/bank_router.sv
hw/sram_bank.sv
hw/resp_merge.sv
hw/mem_stage.sv
hw/mem_subsys_top.sv
dv/tb_mem_subsys.sv

//--- run.sh
#!/bin/sh
# build and run tb_mem_subsys with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sources.f --top-module tb_mem_subsys -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TEST OK" sim.log || { echo "no result line in sim.log"; exit 1; }
exit 0

//--- dv/tb_mem_subsys.sv
`timescale 1ns/100ps
`include "mem_consts.svh"

module tb_mem_subsys import mem_pkg::*; ();

    localparam int WAIT_LIMIT = 50;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    logic       in_ready;
    ex_mem_t    in_bundle;
    logic       out_valid;
    logic       out_ready;
    mem_wb_t    out_bundle;

    integer     seed;
    integer     bp_seed;
    bit         bp_mode;
    bit         hung;                 // later waits are skipped after a timeout
    string      test_name;
    logic [7:0] ref_mem [4096];       // byte addressed model of all banks
    mem_wb_t    exp_q [$];
    mem_wb_t    exp_b;
    int         mismatches;
    int         proto_errs;
    int         timeouts;
    int         n_sent;
    int         n_out;

    mem_subsys_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_bundle  (in_bundle),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_bundle (out_bundle)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // write-back side stalls at random while bp_mode is on
    initial begin
        int low_left;
        low_left  = 0;
        out_ready = 1'b1;
        bp_seed   = 32'hea97e324;   // own stream
        forever begin
            @(negedge clk);
            if (low_left > 0) begin
                out_ready = 1'b0;
                low_left--;
            end else begin
                out_ready = 1'b1;
                if (bp_mode)
                    low_left = $random(bp_seed) & 7;
            end
        end
    end

    stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
            out_valid && !out_ready |=> $stable(out_bundle))
        else begin
            proto_errs++;
            $display("out_bundle changed while the write-back side stalled (%s)", test_name);
        end

    stall_held: assert property (@(posedge clk) disable iff (!rst_n)
            out_valid && !out_ready |=> out_valid)
        else begin
            proto_errs++;
            $display("out_valid dropped before the bundle was taken (%s)", test_name);
        end

    stall_blocks_input: assert property (@(posedge clk) disable iff (!rst_n)
            out_valid && !out_ready |-> !in_ready)
        else begin
            proto_errs++;
            $display("in_ready high while the output was stalled (%s)", test_name);
        end

    // in-order scoreboard
    always @(posedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            n_out++;
            assert (exp_q.size() > 0) else begin
                proto_errs++;
                $display("bundle came out in %s with nothing expected", test_name);
            end
            if (exp_q.size() > 0) begin
                exp_b = exp_q.pop_front();
                assert (out_bundle == exp_b) else begin
                    mismatches++;
                    $display("MISMATCH %s: expected %h, actual %h",
                             test_name, exp_b, out_bundle);
                end
            end
        end
    end

    task automatic timed_out(input string what);
        if (!hung)
            $display("timeout in %s: %s", test_name, what);
        timeouts++;
        hung = 1'b1;
    endtask

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e3779b1) ^ 32'h5a5aa5a5;
    endfunction

    function automatic logic [31:0] rand_addr(input mem_op_e op);
        logic [31:0] a;
        a = $random(seed);
        case (op)
            op_none:             ;   // any alu result
            op_lw, op_sw:        a = a & 32'h0000_0ffc;
            op_lh, op_lhu, op_sh: a = a & 32'h0000_0ffe;
            default:             a = a & 32'h0000_0fff;
        endcase
        return a;
    endfunction

    function automatic ex_mem_t make_bundle(input mem_op_e op, input logic [31:0] addr);
        ex_mem_t b;
        b.pc         = $random(seed);
        b.inst       = $random(seed);
        b.alu_result = addr;
        b.csr_value  = $random(seed);
        b.store_data = $random(seed);
        b.rd         = 5'($random(seed));
        b.rd_wen     = 1'($random(seed));
        b.csr_wen    = 4'($random(seed));
        b.jump_flag  = 1'($random(seed));
        b.mem_op     = op;
        return b;
    endfunction

    // little endian RV32I semantics on the byte model
    task automatic predict(input ex_mem_t b);
        mem_wb_t     e;
        logic [11:0] a;
        logic [15:0] h;
        a            = b.alu_result[11:0];
        h            = {ref_mem[a + 12'd1], ref_mem[a]};
        e            = '0;
        e.pc         = b.pc;
        e.inst       = b.inst;
        e.alu_result = b.alu_result;
        e.csr_value  = b.csr_value;
        e.rd         = b.rd;
        e.rd_wen     = b.rd_wen;
        e.csr_wen    = b.csr_wen;
        e.jump_flag  = b.jump_flag;
        e.is_load    = b.mem_op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
        case (b.mem_op)
            op_lb:  e.load_data = {{24{ref_mem[a][7]}}, ref_mem[a]};
            op_lbu: e.load_data = {24'h0, ref_mem[a]};
            op_lh:  e.load_data = {{16{h[15]}}, h};
            op_lhu: e.load_data = {16'h0, h};
            op_lw:  e.load_data = {ref_mem[a + 12'd3], ref_mem[a + 12'd2], h};
            op_sb:  ref_mem[a] = b.store_data[7:0];
            op_sh: begin
                ref_mem[a]         = b.store_data[7:0];
                ref_mem[a + 12'd1] = b.store_data[15:8];
            end
            op_sw: begin
                ref_mem[a]         = b.store_data[7:0];
                ref_mem[a + 12'd1] = b.store_data[15:8];
                ref_mem[a + 12'd2] = b.store_data[23:16];
                ref_mem[a + 12'd3] = b.store_data[31:24];
            end
            default: ;
        endcase
        exp_q.push_back(e);
        n_sent++;
    endtask

    // starts and ends right after a falling edge
    task automatic send_bundle(input ex_mem_t b);
        int cycles;
        if (hung)
            return;
        in_valid  = 1'b1;
        in_bundle = b;
        cycles    = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!in_ready && cycles < WAIT_LIMIT);
        if (in_ready)
            predict(b);
        else
            timed_out("bundle not accepted");
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < WAIT_LIMIT && !hung) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0)
            timed_out("results did not come out");
    endtask

    task automatic random_stream(input int n, input bit gaps);
        int      k;
        mem_op_e op;
        for (int i = 0; i < n; i++) begin
            k  = $random(seed) & 15;
            op = (k > 8) ? op_none : mem_op_e'(4'(k));   // extra weight on alu ops
            send_bundle(make_bundle(op, rand_addr(op)));
            if (gaps)
                repeat ($random(seed) & 3) @(negedge clk);
        end
        wait_drain();
    endtask

    initial begin
        ex_mem_t     b;
        logic [31:0] a;
        seed      = 32'hea97e324;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_bundle = '0;
        test_name = "reset";
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (out_valid == 1'b0) else begin
            mismatches++;
            $display("MISMATCH %s: out_valid expected 0, actual %b", test_name, out_valid);
        end
        assert (in_ready == 1'b1) else begin
            mismatches++;
            $display("MISMATCH %s: in_ready expected 1, actual %b", test_name, in_ready);
        end

        // every word written once so no load sees unwritten data
        test_name = "fill";
        for (int w = 0; w < 1024; w++) begin
            b            = make_bundle(op_sw, 32'(w) << 2);
            b.store_data = fill_word(32'(w) << 2);
            send_bundle(b);
        end
        wait_drain();

        test_name = "alu_pass";
        for (int i = 0; i < 32; i++)
            send_bundle(make_bundle(op_none, $random(seed)));
        wait_drain();

        test_name = "word_round_trip";
        for (int i = 0; i < 32; i++) begin
            a = (rand_addr(op_sw) & 32'hffff_fff3) | (32'(i % `MEM_NR_BANKS) << 2);
            send_bundle(make_bundle(op_sw, a));
            send_bundle(make_bundle(op_lw, a));
        end
        wait_drain();

        test_name = "byte_half";
        for (int i = 0; i < 8; i++) begin
            a = rand_addr(op_sw);
            for (int lane = 0; lane < 4; lane++) begin
                send_bundle(make_bundle(op_sb, a + 32'(lane)));
                send_bundle(make_bundle(op_lb, a + 32'(lane)));
                send_bundle(make_bundle(op_lbu, a + 32'(lane)));
                send_bundle(make_bundle(op_lw, a));
            end
            for (int lane = 0; lane < 4; lane += 2) begin
                send_bundle(make_bundle(op_sh, a + 32'(lane)));
                send_bundle(make_bundle(op_lh, a + 32'(lane)));
                send_bundle(make_bundle(op_lhu, a + 32'(lane)));
                send_bundle(make_bundle(op_lw, a));
            end
        end
        wait_drain();

        test_name = "back_pressure";
        bp_mode   = 1'b1;
        random_stream(300, 1'b0);
        bp_mode   = 1'b0;

        test_name = "mixed_stream";
        random_stream(400, 1'b1);

        test_name = "end";
        assert (n_out == n_sent) else begin
            proto_errs++;
            $display("%0d bundles were accepted but %0d came out", n_sent, n_out);
        end
        $display("%0d bundles checked, %0d mismatches, %0d protocol errors, %0d timeouts",
                 n_out, mismatches, proto_errs, timeouts);
        if (mismatches == 0 && proto_errs == 0 && timeouts == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- hw/mem_subsys_top.sv
`timescale 1ns/100ps
`include "mem_consts.svh"

module mem_subsys_top import mem_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,

    input  logic    in_valid,
    output logic    in_ready,
    input  ex_mem_t in_bundle,

    output logic    out_valid,
    input  logic    out_ready,
    output mem_wb_t out_bundle
);

    logic                     req_valid;
    logic                     req_ready;
    mem_req_t                 req;

    logic [`MEM_NR_BANKS-1:0] bank_req_valid;
    logic [`MEM_NR_BANKS-1:0] bank_req_ready;
    logic [`MEM_NR_BANKS-1:0] rsp_valid;
    bank_rsp_t                rsp [`MEM_NR_BANKS];

    logic                     load_valid;
    logic                     load_ready;
    logic [`MEM_XLEN-1:0]     load_rdata;

    mem_stage i_mem_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_bundle  (in_bundle),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_bundle (out_bundle),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .load_valid (load_valid),
        .load_ready (load_ready),
        .load_rdata (load_rdata)
    );

    bank_router i_bank_router (
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req            (req),
        .bank_req_valid (bank_req_valid),
        .bank_req_ready (bank_req_ready)
    );

    // all banks share the request payload
    for (genvar i = 0; i < `MEM_NR_BANKS; i++) begin : g_bank
        sram_bank i_sram_bank (
            .clk       (clk),
            .rst_n     (rst_n),
            .req_valid (bank_req_valid[i]),
            .req_ready (bank_req_ready[i]),
            .req       (req),
            .rsp_valid (rsp_valid[i]),
            .rsp       (rsp[i])
        );
    end

    resp_merge i_resp_merge (
        .clk        (clk),
        .rst_n      (rst_n),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .load_valid (load_valid),
        .load_ready (load_ready),
        .load_rdata (load_rdata)
    );

endmodule

//--- hw/mem_stage.sv
`timescale 1ns/100ps
`include "mem_consts.svh"

module mem_stage import mem_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 in_valid,
    output logic                 in_ready,
    input  ex_mem_t              in_bundle,

    output logic                 out_valid,
    input  logic                 out_ready,
    output mem_wb_t              out_bundle,

    output logic                 req_valid,
    input  logic                 req_ready,
    output mem_req_t             req,

    input  logic                 load_valid,
    output logic                 load_ready,
    input  logic [`MEM_XLEN-1:0] load_rdata
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_req,
        st_wait_load
    } state_e;

    state_e                   state;
    ex_mem_t                  bundle_q;
    logic                     out_valid_q;     // finished result held in output reg
    logic [`MEM_XLEN-1:0]     load_data_q;

    logic                     in_fire;
    logic                     out_fire;
    logic                     req_fire;
    logic [1:0]               offset;
    logic [`MEM_NR_LANES-1:0] strb_base;
    logic [`MEM_XLEN-1:0]     load_shifted;
    logic [`MEM_XLEN-1:0]     load_ext;

    function automatic logic is_load_op(mem_op_e op);
        return op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
    endfunction

    function automatic logic is_store_op(mem_op_e op);
        return op inside {op_sb, op_sh, op_sw};
    endfunction

    assign in_fire  = in_valid && in_ready;
    assign out_fire = out_valid && out_ready;
    assign req_fire = req_valid && req_ready;
    assign offset   = bundle_q.alu_result[1:0];

    // old result may leave while a new bundle enters
    assign in_ready   = (state == st_idle) && (!out_valid_q || out_ready);
    assign out_valid  = out_valid_q ||
                        (state == st_wait_req && is_store_op(bundle_q.mem_op) && req_ready);
    assign req_valid  = (state == st_wait_req);
    assign load_ready = (state == st_wait_load);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= st_idle;
            out_valid_q <= 1'b0;
        end else begin
            if (out_fire)
                out_valid_q <= 1'b0;
            case (state)
                st_idle: begin
                    if (in_fire) begin
                        if (in_bundle.mem_op != op_none)
                            state <= st_wait_req;
                        else
                            out_valid_q <= 1'b1;
                    end
                end
                st_wait_req: begin
                    if (req_fire) begin
                        if (is_store_op(bundle_q.mem_op)) begin
                            state       <= st_idle;
                            out_valid_q <= !out_ready;   // keep it if not taken now
                        end else begin
                            state <= st_wait_load;
                        end
                    end
                end
                st_wait_load: begin
                    if (load_valid) begin
                        state       <= st_idle;
                        out_valid_q <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire)
            bundle_q <= in_bundle;
        if (load_valid && load_ready)
            load_data_q <= load_ext;
    end

    // store lanes before the address offset
    always_comb begin
        case (bundle_q.mem_op)
            op_sb:   strb_base = 4'b0001;
            op_sh:   strb_base = 4'b0011;
            op_sw:   strb_base = 4'b1111;
            default: strb_base = 4'b0000;
        endcase
    end

    always_comb begin
        req.addr  = {bundle_q.alu_result[`MEM_XLEN-1:2], 2'b00};
        req.wdata = bundle_q.store_data << {offset, 3'b000};
        req.wstrb = strb_base << offset;
        req.write = is_store_op(bundle_q.mem_op);
    end

    assign load_shifted = load_rdata >> {offset, 3'b000};

    always_comb begin
        case (bundle_q.mem_op)
            op_lb:   load_ext = {{(`MEM_XLEN-8){load_shifted[7]}}, load_shifted[7:0]};
            op_lh:   load_ext = {{(`MEM_XLEN-16){load_shifted[15]}}, load_shifted[15:0]};
            op_lbu:  load_ext = {{(`MEM_XLEN-8){1'b0}}, load_shifted[7:0]};
            op_lhu:  load_ext = {{(`MEM_XLEN-16){1'b0}}, load_shifted[15:0]};
            op_lw:   load_ext = load_shifted;
            default: load_ext = '0;
        endcase
    end

    always_comb begin
        out_bundle.pc         = bundle_q.pc;
        out_bundle.inst       = bundle_q.inst;
        out_bundle.alu_result = bundle_q.alu_result;
        out_bundle.csr_value  = bundle_q.csr_value;
        out_bundle.is_load    = is_load_op(bundle_q.mem_op);
        out_bundle.load_data  = is_load_op(bundle_q.mem_op) ? load_data_q : '0;
        out_bundle.rd         = bundle_q.rd;
        out_bundle.rd_wen     = bundle_q.rd_wen;
        out_bundle.csr_wen    = bundle_q.csr_wen;
        out_bundle.jump_flag  = bundle_q.jump_flag;
    end

endmodule

//--- hw/resp_merge.sv
`timescale 1ns/100ps
`include "mem_consts.svh"

module resp_merge import mem_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic [`MEM_NR_BANKS-1:0] rsp_valid,
    input  bank_rsp_t                rsp [`MEM_NR_BANKS],

    output logic                     load_valid,
    input  logic                     load_ready,
    output logic [`MEM_XLEN-1:0]     load_rdata
);

    logic                 sel_valid;
    logic [`MEM_XLEN-1:0] sel_data;

    // lowest bank index wins
    always_comb begin
        sel_data = '0;
        for (int i = `MEM_NR_BANKS-1; i >= 0; i--) begin
            if (rsp_valid[i])
                sel_data = rsp[i].rdata;
        end
    end

    assign sel_valid = |rsp_valid;

    always_ff @(posedge clk) begin
        if (!rst_n)
            load_valid <= 1'b0;
        else if (sel_valid)
            load_valid <= 1'b1;
        else if (load_ready)
            load_valid <= 1'b0;   // taken by the stage
    end

    always_ff @(posedge clk) begin
        if (sel_valid)
            load_rdata <= sel_data;
    end

endmodule

//--- hw/sram_bank.sv
`timescale 1ns/100ps
`include "mem_consts.svh"

module sram_bank import mem_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      req_valid,
    output logic      req_ready,
    input  mem_req_t  req,

    output logic      rsp_valid,
    output bank_rsp_t rsp
);

    logic [`MEM_XLEN-1:0]     mem_q [`MEM_BANK_DEPTH];
    logic [`MEM_ROW_BITS-1:0] row;
    logic                     rd_fire;
    logic                     wr_fire;

    // row bits sit above the bank select bits
    assign row = req.addr[`MEM_ROW_BITS+`MEM_BANK_BITS+1:`MEM_BANK_BITS+2];

    // busy only while the read response is out
    assign req_ready = !rsp_valid;

    assign rd_fire = req_valid && req_ready && !req.write;
    assign wr_fire = req_valid && req_ready && req.write;

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int b = 0; b < `MEM_NR_LANES; b++) begin
                if (req.wstrb[b])
                    mem_q[row][b*8 +: 8] <= req.wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire)
            rsp.rdata <= mem_q[row];
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= rd_fire;   // single cycle pulse
    end

endmodule

//--- hw/bank_router.sv
`timescale 1ns/100ps
`include "mem_consts.svh"

module bank_router import mem_pkg::*; (
    input  logic                     req_valid,
    output logic                     req_ready,
    input  mem_req_t                 req,

    output logic [`MEM_NR_BANKS-1:0] bank_req_valid,
    input  logic [`MEM_NR_BANKS-1:0] bank_req_ready
);

    logic [`MEM_BANK_BITS-1:0] bank_sel;
    logic [`MEM_NR_BANKS-1:0]  bank_hit;

    // bank index sits right above the byte offset
    assign bank_sel = req.addr[`MEM_BANK_BITS+1:2];

    always_comb begin
        for (int i = 0; i < `MEM_NR_BANKS; i++) begin
            bank_hit[i] = (bank_sel == i[`MEM_BANK_BITS-1:0]);
        end
    end

    // only the addressed bank sees a valid
    assign bank_req_valid = bank_hit & {`MEM_NR_BANKS{req_valid}};

    // ready of the addressed bank only
    assign req_ready = |(bank_hit & bank_req_ready);

endmodule

//--- hw/mem_pkg.sv
`include "mem_consts.svh"

package mem_pkg;

    // memory op of the bundle in place of raw funct3
    typedef enum logic [3:0] {
        op_none = 4'd0,
        op_lb   = 4'd1,
        op_lh   = 4'd2,
        op_lw   = 4'd3,
        op_lbu  = 4'd4,
        op_lhu  = 4'd5,
        op_sb   = 4'd6,
        op_sh   = 4'd7,
        op_sw   = 4'd8
    } mem_op_e;

    // bundle from execute
    typedef struct packed {
        logic [`MEM_XLEN-1:0] pc;
        logic [`MEM_XLEN-1:0] inst;
        logic [`MEM_XLEN-1:0] alu_result;   // also the address
        logic [`MEM_XLEN-1:0] csr_value;
        logic [`MEM_XLEN-1:0] store_data;
        logic [4:0]           rd;
        logic                 rd_wen;
        logic [3:0]           csr_wen;
        logic                 jump_flag;
        mem_op_e              mem_op;
    } ex_mem_t;

    // bundle toward write-back
    typedef struct packed {
        logic [`MEM_XLEN-1:0] pc;
        logic [`MEM_XLEN-1:0] inst;
        logic [`MEM_XLEN-1:0] alu_result;
        logic [`MEM_XLEN-1:0] csr_value;
        logic [`MEM_XLEN-1:0] load_data;
        logic [4:0]           rd;
        logic                 rd_wen;
        logic [3:0]           csr_wen;
        logic                 jump_flag;
        logic                 is_load;
    } mem_wb_t;

    // word request with byte strobes for writes
    typedef struct packed {
        logic [`MEM_XLEN-1:0]     addr;
        logic [`MEM_XLEN-1:0]     wdata;
        logic [`MEM_NR_LANES-1:0] wstrb;
        logic                     write;
    } mem_req_t;

    // read data from one bank
    typedef struct packed {
        logic [`MEM_XLEN-1:0] rdata;
    } bank_rsp_t;

endpackage

//--- hw/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// data and address width
`define MEM_XLEN        32

// bank count must be a power of two
`define MEM_NR_BANKS    4
`define MEM_BANK_BITS   2     // addr[3:2]

// words per bank
`define MEM_BANK_DEPTH  256
`define MEM_ROW_BITS    8     // addr bits above the bank bits

// byte lanes per word
`define MEM_NR_LANES    (`MEM_XLEN / 8)

`endif
